// File: tests/hash_check_trace.txt
# C fid hash serial | B test sop eop data gap | X data sop eop discard serial_err | H hash
# Numbers are hex except gap, the decimal count of idle cycles before the beat.
C 1 44400004 11
C 2 44400121 22
C 3 e6600006 34
C 4 44400000 44
C 5 5a800004 56
B basic_match 1 0 11100001 0
B basic_match 0 0 00000002 0
B basic_match 0 1 00000004 0
H 44400004
X 11100001 1 0 0 0
X 00000002 0 0 0 0
X 00000004 0 1 0 0
B hash_mismatch 1 0 22200010 0
B hash_mismatch 0 1 00000100 0
H 44400120
X 22200010 1 0 1 0
X 00000100 0 1 1 0
B serial_mismatch 1 0 33300003 0
B serial_mismatch 0 1 80000000 2
H e6600006
X 33300003 1 0 0 1
X 80000000 0 1 0 1
B back_to_back 1 1 44400000 0
H 44400000
X 44400000 1 1 0 0
B back_to_back 1 0 55500000 0
B back_to_back 0 0 00000001 0
B back_to_back 0 0 00000001 0
B back_to_back 0 1 f0000000 0
H 5a800004
X 55500000 1 0 0 1
X 00000001 0 0 0 1
X 00000001 0 0 0 1
X f0000000 0 1 0 1
B back_to_back 1 0 11100000 0
B back_to_back 0 1 00000005 0
H 22200005
X 11100000 1 0 1 0
X 00000005 0 1 1 0
B unconfigured 1 0 f0000001 0
B unconfigured 0 1 00000003 0
H e0000000
X f0000001 1 0 1 0
X 00000003 0 1 1 0
B unconfigured 1 1 e0700000 0
H e0700000
X e0700000 1 1 1 1

// File: compile.f
hdl/hash_check_pkg.sv
hdl/flow_table.sv
hdl/packet_hash_gen.sv
hdl/packet_buffer.sv
hdl/hash_check.sv
hdl/hash_check_top.sv
tests/hash_check_assertions.sv
tests/hash_check_tb.sv

// File: Bender.yml
package:
  name: hash_check

sources:
  - hdl/hash_check_pkg.sv
  - hdl/flow_table.sv
  - hdl/packet_hash_gen.sv
  - hdl/packet_buffer.sv
  - hdl/hash_check.sv
  - hdl/hash_check_top.sv
  - target: test
    files:
      - tests/hash_check_assertions.sv
      - tests/hash_check_tb.sv

// File: tests/hash_check_tb.sv
`timescale 1ns/100ps

module hash_check_tb;

        localparam trace_file = "tests/hash_check_trace.txt";

        logic clk;
        logic reset;
        logic in_valid;
        logic [hash_check_pkg::data_width-1:0] in_data;
        logic in_sop;
        logic in_eop;
        logic cfg_wr;
        logic [hash_check_pkg::fid_width-1:0] cfg_fid;
        logic [hash_check_pkg::data_width-1:0] cfg_hash;
        logic [hash_check_pkg::serial_width-1:0] cfg_serial;
        logic out_valid;
        logic [hash_check_pkg::data_width-1:0] out_data;
        logic out_sop;
        logic out_eop;
        logic out_discard;
        logic out_serial_err;
        logic hash_valid;
        logic [hash_check_pkg::data_width-1:0] hash_data;

        // Trace contents.
        logic [hash_check_pkg::fid_width-1:0] cfg_fid_q [$];
        logic [hash_check_pkg::data_width-1:0] cfg_hash_q [$];
        logic [hash_check_pkg::serial_width-1:0] cfg_serial_q [$];
        string beat_name_q [$];
        logic beat_sop_q [$];
        logic beat_eop_q [$];
        logic [hash_check_pkg::data_width-1:0] beat_data_q [$];
        int beat_gap_q [$];

        // Expected beats packed as data, sop, eop, discard, serial_err.
        logic [hash_check_pkg::data_width+3:0] exp_beat_q [$];
        logic [hash_check_pkg::data_width-1:0] exp_hash_q [$];
        string out_name_q [$];
        string hash_name_q [$];
        string out_name;
        int errors;
        int checks;
        int watch_cycles;

        hash_check_top dut_i (
                .clk            (clk),
                .reset          (reset),
                .in_valid       (in_valid),
                .in_data        (in_data),
                .in_sop         (in_sop),
                .in_eop         (in_eop),
                .cfg_wr         (cfg_wr),
                .cfg_fid        (cfg_fid),
                .cfg_hash       (cfg_hash),
                .cfg_serial     (cfg_serial),
                .out_valid      (out_valid),
                .out_data       (out_data),
                .out_sop        (out_sop),
                .out_eop        (out_eop),
                .out_discard    (out_discard),
                .out_serial_err (out_serial_err),
                .hash_valid     (hash_valid),
                .hash_data      (hash_data)
        );

        always #2 clk = ~clk;

        task automatic check(input string name, input string field,
                             input logic [hash_check_pkg::data_width-1:0] expected,
                             input logic [hash_check_pkg::data_width-1:0] actual);
                checks++;
                if (actual !== expected) begin
                        errors++;
                        $display("Error: %s %s expected %h actual %h", name, field, expected, actual);
                end
        endtask

        // ------------------------------
        // Trace reader
        // ------------------------------

        task automatic read_trace(input int fd);
                string line;
                string kind;
                string name;
                logic [hash_check_pkg::fid_width-1:0] fid;
                logic [hash_check_pkg::data_width-1:0] data;
                logic [hash_check_pkg::serial_width-1:0] serial;
                logic sop;
                logic eop;
                logic discard;
                logic serial_err;
                int gap;
                while (!$feof(fd)) begin
                        line = "";
                        kind = "";
                        void'($fgets(line, fd));
                        void'($sscanf(line, "%s", kind));
                        case (kind)
                                "C": begin
                                        void'($sscanf(line, "%s %h %h %h", kind, fid, data, serial));
                                        cfg_fid_q.push_back(fid);
                                        cfg_hash_q.push_back(data);
                                        cfg_serial_q.push_back(serial);
                                end
                                "B": begin
                                        void'($sscanf(line, "%s %s %h %h %h %d",
                                                      kind, name, sop, eop, data, gap));
                                        beat_name_q.push_back(name);
                                        beat_sop_q.push_back(sop);
                                        beat_eop_q.push_back(eop);
                                        beat_data_q.push_back(data);
                                        beat_gap_q.push_back(gap);
                                        if (sop) begin
                                                out_name_q.push_back(name);
                                                hash_name_q.push_back(name);
                                        end
                                end
                                "X": begin
                                        void'($sscanf(line, "%s %h %h %h %h %h",
                                                      kind, data, sop, eop, discard, serial_err));
                                        exp_beat_q.push_back({data, sop, eop, discard, serial_err});
                                end
                                "H": begin
                                        void'($sscanf(line, "%s %h", kind, data));
                                        exp_hash_q.push_back(data);
                                end
                                default: ;
                        endcase
                end
        endtask

        // ------------------------------
        // Drivers
        // ------------------------------

        task automatic write_table();
                int i;
                for (i = 0; i < cfg_fid_q.size(); i++) begin
                        @(posedge clk);
                        cfg_wr <= 1'b1;
                        cfg_fid <= cfg_fid_q[i];
                        cfg_hash <= cfg_hash_q[i];
                        cfg_serial <= cfg_serial_q[i];
                end
                @(posedge clk);
                cfg_wr <= 1'b0;
        endtask

        task automatic send_beats();
                int i;
                int idle;
                hash_check_pkg::pkt_word_u word;
                for (i = 0; i < beat_data_q.size(); i++) begin
                        idle = beat_gap_q[i];
                        word.raw = beat_data_q[i];
                        if (beat_sop_q[i]) begin
                                // Packets of one test keep the trace's spacing.
                                if (i == 0 || beat_name_q[i] != beat_name_q[i-1])
                                        idle = idle + ($urandom % 4);
                                $display("%s: flow %0d serial %h", beat_name_q[i],
                                         word.hdr.fid, word.hdr.serial);
                        end
                        repeat (idle) begin
                                @(posedge clk);
                                in_valid <= 1'b0;
                                in_sop <= 1'b0;
                                in_eop <= 1'b0;
                        end
                        @(posedge clk);
                        in_valid <= 1'b1;
                        in_data <= word.raw;
                        in_sop <= beat_sop_q[i];
                        in_eop <= beat_eop_q[i];
                end
                @(posedge clk);
                in_valid <= 1'b0;
                in_sop <= 1'b0;
                in_eop <= 1'b0;
        endtask

        // ------------------------------
        // Monitor
        // ------------------------------

        task automatic compare_beat();
                logic [hash_check_pkg::data_width+3:0] want;
                if (exp_beat_q.size() == 0) begin
                        errors++;
                        $display("Output beat %h arrived after all expected beats", out_data);
                end else begin
                        want = exp_beat_q.pop_front();
                        if (want[3] && out_name_q.size() > 0)
                                out_name = out_name_q.pop_front();
                        check(out_name, "data", want[hash_check_pkg::data_width+3:4], out_data);
                        check(out_name, "sop", want[3], out_sop);
                        check(out_name, "eop", want[2], out_eop);
                        check(out_name, "discard", want[1], out_discard);
                        check(out_name, "serial_err", want[0], out_serial_err);
                end
        endtask

        task automatic compare_hash();
                string name;
                name = "unknown";
                if (exp_hash_q.size() == 0) begin
                        errors++;
                        $display("Hash pulse %h arrived after all expected hashes", hash_data);
                end else begin
                        if (hash_name_q.size() > 0)
                                name = hash_name_q.pop_front();
                        check(name, "hash", exp_hash_q.pop_front(), hash_data);
                end
        endtask

        // Sampled away from the rising edge.
        always @(negedge clk) begin
                if (!reset && out_valid)
                        compare_beat();
                if (!reset && hash_valid)
                        compare_hash();
        end

        task automatic run_tests();
                watch_cycles = beat_data_q.size() * 4 + 200;
                repeat (5) @(posedge clk);
                reset <= 1'b0;
                // Clear sweep of the flow table.
                repeat (20) @(posedge clk);
                write_table();
                send_beats();
                while (exp_beat_q.size() > 0 || exp_hash_q.size() > 0)
                        @(posedge clk);
                repeat (20) @(posedge clk);
                $display("Checks: %0d, errors: %0d", checks, errors);
                if (errors == 0 && checks > 0)
                        $display("all tests passed");
                else
                        $display("tests failed");
                $finish;
        endtask

        initial begin
                int fd;
                clk = 1'b0;
                reset = 1'b1;
                in_valid = 1'b0;
                in_data = '0;
                in_sop = 1'b0;
                in_eop = 1'b0;
                cfg_wr = 1'b0;
                cfg_fid = '0;
                cfg_hash = '0;
                cfg_serial = '0;
                errors = 0;
                checks = 0;
                void'($urandom(73358));
                fd = $fopen(trace_file, "r");
                if (fd == 0) begin
                        $display("Could not open the trace file %s", trace_file);
                        $display("tests failed");
                        $finish;
                end else begin
                        read_trace(fd);
                        $fclose(fd);
                        run_tests();
                end
        end

        // Watchdog.
        initial begin
                wait (watch_cycles > 0);
                repeat (watch_cycles) @(posedge clk);
                $display("Timeout after %0d cycles with %0d beats and %0d hashes still expected",
                         watch_cycles, exp_beat_q.size(), exp_hash_q.size());
                $display("tests failed");
                $finish;
        end

endmodule

// File: tests/hash_check_assertions.sv
`timescale 1ns/100ps

module hash_check_assertions (
        input logic clk,
        input logic reset,
        input logic wr_en,
        input logic full,
        input logic out_valid,
        input logic out_sop,
        input logic out_eop,
        input logic out_discard,
        input logic hash_valid
);

        logic [3:0] in_flight;

        // Packets hashed but not yet started on the output.
        always_ff @(posedge clk) begin
                if (reset)
                        in_flight <= '0;
                else
                        in_flight <= in_flight + 4'(hash_valid) - 4'(out_sop);
        end

        no_write_when_full: assert property (@(posedge clk) disable iff (reset)
                wr_en |-> !full)
                else $error("Buffer written while full.");

        marks_need_valid: assert property (@(posedge clk) disable iff (reset)
                (out_sop || out_eop) |-> out_valid)
                else $error("Output sop or eop without out_valid.");

        discard_steady: assert property (@(posedge clk) disable iff (reset)
                (out_valid && !out_sop) |-> out_discard == $past(out_discard))
                else $error("out_discard changed inside a packet.");

        no_hash_in_reset: assert property (@(posedge clk)
                reset |-> !$rose(hash_valid))
                else $error("hash_valid rose during reset.");

        queue_limit: assert property (@(posedge clk) disable iff (reset)
                in_flight <= hash_check_pkg::queue_depth)
                else $error("Result queue depth exceeded.");

endmodule

bind hash_check_top hash_check_assertions assertions_i (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (wr_en),
        .full        (full),
        .out_valid   (out_valid),
        .out_sop     (out_sop),
        .out_eop     (out_eop),
        .out_discard (out_discard),
        .hash_valid  (hash_valid)
);

// File: hdl/hash_check_top.sv
`timescale 1ns/100ps

module hash_check_top (
        input  logic clk,
        input  logic reset,
        input  logic in_valid,
        input  logic [hash_check_pkg::data_width-1:0] in_data,
        input  logic in_sop,
        input  logic in_eop,
        input  logic cfg_wr,
        input  logic [hash_check_pkg::fid_width-1:0] cfg_fid,
        input  logic [hash_check_pkg::data_width-1:0] cfg_hash,
        input  logic [hash_check_pkg::serial_width-1:0] cfg_serial,
        output logic out_valid,
        output logic [hash_check_pkg::data_width-1:0] out_data,
        output logic out_sop,
        output logic out_eop,
        output logic out_discard,
        output logic out_serial_err,
        output logic hash_valid,
        output logic [hash_check_pkg::data_width-1:0] hash_data
);

        logic wr_en;
        logic [hash_check_pkg::data_width-1:0] wr_data;
        logic wr_sop;
        logic wr_eop;
        logic lookup;
        logic [hash_check_pkg::fid_width-1:0] lookup_fid;
        logic [hash_check_pkg::serial_width-1:0] pkt_serial;
        logic exp_valid;
        logic [hash_check_pkg::data_width-1:0] exp_hash;
        logic [hash_check_pkg::serial_width-1:0] exp_serial;
        logic rd_en;
        logic [hash_check_pkg::data_width-1:0] rd_data;
        logic rd_sop;
        logic rd_eop;
        logic empty;
        logic full;

        packet_hash_gen u_packet_hash_gen (
                .clk        (clk),
                .reset      (reset),
                .in_valid   (in_valid),
                .in_data    (in_data),
                .in_sop     (in_sop),
                .in_eop     (in_eop),
                .wr_en      (wr_en),
                .wr_data    (wr_data),
                .wr_sop     (wr_sop),
                .wr_eop     (wr_eop),
                .lookup     (lookup),
                .lookup_fid (lookup_fid),
                .hash_valid (hash_valid),
                .hash_data  (hash_data),
                .pkt_serial (pkt_serial)
        );

        flow_table u_flow_table (
                .clk        (clk),
                .reset      (reset),
                .cfg_wr     (cfg_wr),
                .cfg_fid    (cfg_fid),
                .cfg_hash   (cfg_hash),
                .cfg_serial (cfg_serial),
                .lookup     (lookup),
                .lookup_fid (lookup_fid),
                .exp_valid  (exp_valid),
                .exp_hash   (exp_hash),
                .exp_serial (exp_serial)
        );

        // Full only feeds the bound checks.
        packet_buffer u_packet_buffer (
                .clk     (clk),
                .reset   (reset),
                .wr_en   (wr_en),
                .wr_data (wr_data),
                .wr_sop  (wr_sop),
                .wr_eop  (wr_eop),
                .rd_en   (rd_en),
                .rd_data (rd_data),
                .rd_sop  (rd_sop),
                .rd_eop  (rd_eop),
                .empty   (empty),
                .full    (full)
        );

        hash_check u_hash_check (
                .clk            (clk),
                .reset          (reset),
                .hash_valid     (hash_valid),
                .hash_data      (hash_data),
                .pkt_serial     (pkt_serial),
                .exp_valid      (exp_valid),
                .exp_hash       (exp_hash),
                .exp_serial     (exp_serial),
                .rd_data        (rd_data),
                .rd_sop         (rd_sop),
                .rd_eop         (rd_eop),
                .empty          (empty),
                .rd_en          (rd_en),
                .out_valid      (out_valid),
                .out_data       (out_data),
                .out_sop        (out_sop),
                .out_eop        (out_eop),
                .out_discard    (out_discard),
                .out_serial_err (out_serial_err)
        );

endmodule

// File: hdl/hash_check.sv
`timescale 1ns/100ps

module hash_check (
        input  logic clk,
        input  logic reset,
        input  logic hash_valid,
        input  logic [hash_check_pkg::data_width-1:0] hash_data,
        input  logic [hash_check_pkg::serial_width-1:0] pkt_serial,
        input  logic exp_valid,
        input  logic [hash_check_pkg::data_width-1:0] exp_hash,
        input  logic [hash_check_pkg::serial_width-1:0] exp_serial,
        input  logic [hash_check_pkg::data_width-1:0] rd_data,
        input  logic rd_sop,
        input  logic rd_eop,
        input  logic empty,
        output logic rd_en,
        output logic out_valid,
        output logic [hash_check_pkg::data_width-1:0] out_data,
        output logic out_sop,
        output logic out_eop,
        output logic out_discard,
        output logic out_serial_err
);

        // Queue 0 holds computed results, queue 1 expected ones.
        logic [hash_check_pkg::data_width+hash_check_pkg::serial_width-1:0]
                q_mem [2][hash_check_pkg::queue_depth];
        logic [hash_check_pkg::data_width+hash_check_pkg::serial_width-1:0] q_din [2];
        logic [hash_check_pkg::data_width+hash_check_pkg::serial_width-1:0] q_head [2];
        logic [$clog2(hash_check_pkg::queue_depth):0] q_wr [2];
        logic [$clog2(hash_check_pkg::queue_depth):0] q_rd [2];
        logic [1:0] q_push;
        logic [1:0] q_empty;

        logic busy;
        logic start;
        logic hash_mismatch;
        logic serial_mismatch;
        logic discard_q;
        logic serial_err_q;

        assign q_push = {exp_valid, hash_valid};
        assign q_din[0] = {hash_data, pkt_serial};
        assign q_din[1] = {exp_hash, exp_serial};

        always_comb begin
                for (int i = 0; i < 2; i++) begin
                        q_empty[i] = q_wr[i] == q_rd[i];
                        q_head[i] = q_mem[i][q_rd[i][$clog2(hash_check_pkg::queue_depth)-1:0]];
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < 2; i++) begin
                                q_wr[i] <= '0;
                                q_rd[i] <= '0;
                        end
                end else begin
                        for (int i = 0; i < 2; i++) begin
                                if (q_push[i])
                                        q_wr[i] <= q_wr[i] + 1'b1;
                                if (start)
                                        q_rd[i] <= q_rd[i] + 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                for (int i = 0; i < 2; i++) begin
                        if (q_push[i])
                                q_mem[i][q_wr[i][$clog2(hash_check_pkg::queue_depth)-1:0]] <= q_din[i];
                end
        end

        // ------------------------------
        // Compare and stream
        // ------------------------------

        assign hash_mismatch = q_head[0][hash_check_pkg::serial_width +: hash_check_pkg::data_width]
                != q_head[1][hash_check_pkg::serial_width +: hash_check_pkg::data_width];
        assign serial_mismatch = q_head[0][hash_check_pkg::serial_width-1:0]
                != q_head[1][hash_check_pkg::serial_width-1:0];

        // A queued hash means the whole packet already sits in the buffer.
        assign start = ~busy & ~(|q_empty) & ~empty;
        assign rd_en = start | busy;

        always_ff @(posedge clk) begin
                if (reset) begin
                        busy <= 1'b0;
                        out_valid <= 1'b0;
                        out_sop <= 1'b0;
                        out_eop <= 1'b0;
                end else begin
                        busy <= rd_en & ~rd_eop;
                        out_valid <= rd_en;
                        out_sop <= rd_en & rd_sop;
                        out_eop <= rd_en & rd_eop;
                end
        end

        // Outcomes latched at start, held for the rest of the packet.
        always_ff @(posedge clk) begin
                if (start) begin
                        discard_q <= hash_mismatch;
                        serial_err_q <= serial_mismatch;
                end
                out_data <= rd_data;
                out_discard <= busy ? discard_q : hash_mismatch;
                out_serial_err <= busy ? serial_err_q : serial_mismatch;
        end

endmodule

// File: hdl/packet_buffer.sv
`timescale 1ns/100ps

module packet_buffer (
        input  logic clk,
        input  logic reset,
        input  logic wr_en,
        input  logic [hash_check_pkg::data_width-1:0] wr_data,
        input  logic wr_sop,
        input  logic wr_eop,
        input  logic rd_en,
        output logic [hash_check_pkg::data_width-1:0] rd_data,
        output logic rd_sop,
        output logic rd_eop,
        output logic empty,
        output logic full
);

        logic [hash_check_pkg::buf_depth_log2:0] wr_ptr;
        logic [hash_check_pkg::buf_depth_log2:0] rd_ptr;
        logic [hash_check_pkg::data_width+1:0] mem [2**hash_check_pkg::buf_depth_log2];

        assign empty = wr_ptr == rd_ptr;

        // Same slot, other lap.
        assign full = (wr_ptr[hash_check_pkg::buf_depth_log2] != rd_ptr[hash_check_pkg::buf_depth_log2])
                && (wr_ptr[hash_check_pkg::buf_depth_log2-1:0]
                    == rd_ptr[hash_check_pkg::buf_depth_log2-1:0]);

        // Head word shows without a read.
        assign {rd_data, rd_sop, rd_eop} = mem[rd_ptr[hash_check_pkg::buf_depth_log2-1:0]];

        always_ff @(posedge clk) begin
                if (reset) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        if (wr_en)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (rd_en)
                                rd_ptr <= rd_ptr + 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (wr_en)
                        mem[wr_ptr[hash_check_pkg::buf_depth_log2-1:0]] <= {wr_data, wr_sop, wr_eop};
        end

endmodule

// File: hdl/packet_hash_gen.sv
`timescale 1ns/100ps

module packet_hash_gen (
        input  logic clk,
        input  logic reset,
        input  logic in_valid,
        input  logic [hash_check_pkg::data_width-1:0] in_data,
        input  logic in_sop,
        input  logic in_eop,
        output logic wr_en,
        output logic [hash_check_pkg::data_width-1:0] wr_data,
        output logic wr_sop,
        output logic wr_eop,
        output logic lookup,
        output logic [hash_check_pkg::fid_width-1:0] lookup_fid,
        output logic hash_valid,
        output logic [hash_check_pkg::data_width-1:0] hash_data,
        output logic [hash_check_pkg::serial_width-1:0] pkt_serial
);

        hash_check_pkg::pkt_word_u beat_q;
        logic valid_q;
        logic sop_q;
        logic eop_q;
        logic [hash_check_pkg::data_width-1:0] next_hash;

        // Registered beat goes straight to the buffer.
        assign wr_en = valid_q;
        assign wr_data = beat_q.raw;
        assign wr_sop = sop_q;
        assign wr_eop = eop_q;

        // Flow lookup on the sop beat.
        assign lookup = valid_q & sop_q;
        assign lookup_fid = beat_q.hdr.fid;

        // Rotate left by one, then fold in the beat.
        assign next_hash = sop_q ? beat_q.raw :
                {hash_data[hash_check_pkg::data_width-2:0],
                 hash_data[hash_check_pkg::data_width-1]} ^ beat_q.raw;

        always_ff @(posedge clk) begin
                if (reset) begin
                        valid_q <= 1'b0;
                        hash_valid <= 1'b0;
                end else begin
                        valid_q <= in_valid;
                        hash_valid <= valid_q & eop_q;
                end
        end

        // Accumulator doubles as hash_data; it holds until the next beat.
        always_ff @(posedge clk) begin
                beat_q.raw <= in_data;
                sop_q <= in_sop;
                eop_q <= in_eop;
                if (valid_q)
                        hash_data <= next_hash;
                if (lookup)
                        pkt_serial <= beat_q.hdr.serial;
        end

endmodule

// File: hdl/flow_table.sv
`timescale 1ns/100ps

module flow_table (
        input  logic clk,
        input  logic reset,
        input  logic cfg_wr,
        input  logic [hash_check_pkg::fid_width-1:0] cfg_fid,
        input  logic [hash_check_pkg::data_width-1:0] cfg_hash,
        input  logic [hash_check_pkg::serial_width-1:0] cfg_serial,
        input  logic lookup,
        input  logic [hash_check_pkg::fid_width-1:0] lookup_fid,
        output logic exp_valid,
        output logic [hash_check_pkg::data_width-1:0] exp_hash,
        output logic [hash_check_pkg::serial_width-1:0] exp_serial
);

        logic wr_q;
        logic [hash_check_pkg::fid_width-1:0] wr_fid_q;
        logic [hash_check_pkg::data_width-1:0] wr_hash_q;
        logic [hash_check_pkg::serial_width-1:0] wr_serial_q;
        logic [hash_check_pkg::fid_width:0] clr_cnt;
        logic clearing;

        logic [hash_check_pkg::data_width-1:0] hash_mem [2**hash_check_pkg::fid_width];
        logic [hash_check_pkg::serial_width-1:0] serial_mem [2**hash_check_pkg::fid_width];

        // Sweep runs until the counter's top bit sets.
        assign clearing = ~clr_cnt[hash_check_pkg::fid_width];

        always_ff @(posedge clk) begin
                if (reset) begin
                        wr_q <= 1'b0;
                        clr_cnt <= '0;
                        exp_valid <= 1'b0;
                end else begin
                        wr_q <= cfg_wr;
                        if (clearing)
                                clr_cnt <= clr_cnt + 1'b1;
                        exp_valid <= lookup;
                end
        end

        always_ff @(posedge clk) begin
                wr_fid_q <= cfg_fid;
                wr_hash_q <= cfg_hash;
                wr_serial_q <= cfg_serial;
                if (lookup) begin
                        exp_hash <= hash_mem[lookup_fid];
                        exp_serial <= serial_mem[lookup_fid];
                end
        end

        // ------------------------------
        // Table memory
        // ------------------------------

        // Writes during the sweep are dropped.
        always_ff @(posedge clk) begin
                if (clearing) begin
                        hash_mem[clr_cnt[hash_check_pkg::fid_width-1:0]] <= '0;
                        serial_mem[clr_cnt[hash_check_pkg::fid_width-1:0]] <= '0;
                end else if (wr_q) begin
                        hash_mem[wr_fid_q] <= wr_hash_q;
                        serial_mem[wr_fid_q] <= wr_serial_q;
                end
        end

endmodule

// File: hdl/hash_check_pkg.sv
package hash_check_pkg;

        // Beat and table field widths.
        localparam int data_width = 32;
        localparam int fid_width = 4;
        localparam int serial_width = 8;

        // Storage depths.
        localparam int buf_depth_log2 = 6;
        localparam int queue_depth = 4;

        // Sop beat, seen as header fields or as a raw word.
        typedef union packed {
                struct packed {
                        logic [fid_width-1:0] fid;
                        logic [serial_width-1:0] serial;
                        logic [data_width-fid_width-serial_width-1:0] rest;
                } hdr;
                logic [data_width-1:0] raw;
        } pkt_word_u;

endpackage
